/* branchUnit.sv */
`timescale 1ns/1ps

module branchUnit (
    input  logic [exPkg::OP_W-1:0]   op,
    input  logic [exPkg::WORD_W-1:0] pc2,
    input  logic [exPkg::WORD_W-1:0] rd1,
    input  logic [exPkg::WORD_W-1:0] imm,
    output logic                     takeBranch,
    output logic [exPkg::WORD_W-1:0] target
);

    logic                     condMet;
    logic                     isJump;
    logic                     regBase;
    logic                     rd1Zero;
    logic                     rd1Neg;
    logic [exPkg::WORD_W-1:0] base;
    logic [exPkg::WORD_W-1:0] sum;

    assign rd1Zero = (rd1 == '0);
    assign rd1Neg  = rd1[exPkg::WORD_W-1];

    always_comb begin
        condMet = 1'b0;
        isJump  = 1'b0;
        regBase = 1'b0;
        case (op)
            exPkg::OP_BEQZ: condMet = rd1Zero;
            exPkg::OP_BNEZ: condMet = ~rd1Zero;
            exPkg::OP_BLTZ: condMet = rd1Neg;
            exPkg::OP_BGEZ: condMet = ~rd1Neg;
            exPkg::OP_J,
            exPkg::OP_JAL:  isJump = 1'b1;
            exPkg::OP_JR,
            exPkg::OP_JALR: begin
                isJump  = 1'b1;
                regBase = 1'b1;
            end
            default: ;
        endcase
    end

    // register-indirect jumps add to rd1, everything else to pc2
    assign base = regBase ? rd1 : pc2;
    assign sum  = base + imm;

    assign takeBranch = condMet | isJump;
    assign target     = takeBranch ? sum : pc2;

endmodule

/* exAlu.sv */
`timescale 1ns/1ps

module exAlu (
    input  logic [exPkg::WORD_W-1:0] a,
    input  logic [exPkg::WORD_W-1:0] b,
    input  logic [exPkg::ALU_W-1:0]  aluOp,
    output logic [exPkg::WORD_W-1:0] y,
    output logic                     carry,
    output logic                     zero,
    output logic                     neg,
    output logic                     aluErr
);

    logic [exPkg::SH_W-1:0]       shAmt;
    logic [exPkg::WORD_W:0]       sum;
    logic [exPkg::WORD_W:0]       diff;
    logic [2*exPkg::WORD_W-1:0]   rolWide;
    logic [2*exPkg::WORD_W-1:0]   rorWide;
    logic [exPkg::WORD_W-1:0]     sllVal;
    logic [exPkg::WORD_W-1:0]     srlVal;

    assign shAmt = b[exPkg::SH_W-1:0];

    assign sum = {1'b0, a} + {1'b0, b};

    // b - a, formed as b + ~a + 1 so the carry is meaningful
    assign diff = {1'b0, b} + {1'b0, ~a} + 1'b1;

    // rotates shift a doubled word and keep one half
    assign rolWide = {a, a} << shAmt;
    assign rorWide = {a, a} >> shAmt;

    assign sllVal = a << shAmt;
    assign srlVal = a >> shAmt;

    always_comb begin
        y      = '0;
        carry  = 1'b0;
        aluErr = 1'b0;
        case (aluOp)
            exPkg::ALU_ADD: begin
                y     = sum[exPkg::WORD_W-1:0];
                carry = sum[exPkg::WORD_W];
            end
            exPkg::ALU_SUB: begin
                y     = diff[exPkg::WORD_W-1:0];
                carry = diff[exPkg::WORD_W];
            end
            exPkg::ALU_XOR: begin
                y = a ^ b;
            end
            exPkg::ALU_ANDN: begin
                y = a & ~b;
            end
            exPkg::ALU_ROL: begin
                y = rolWide[2*exPkg::WORD_W-1:exPkg::WORD_W];
            end
            exPkg::ALU_SLL: begin
                y = sllVal;
            end
            exPkg::ALU_ROR: begin
                y = rorWide[exPkg::WORD_W-1:0];
            end
            exPkg::ALU_SRL: begin
                y = srlVal;
            end
            default: begin
                aluErr = 1'b1;
            end
        endcase
    end

    assign zero = (y == '0);
    assign neg  = y[exPkg::WORD_W-1];

endmodule

/* exDecode.sv */
`timescale 1ns/1ps

module exDecode (
    input  logic [exPkg::OP_W-1:0]  op,
    input  logic [exPkg::FN_W-1:0]  fn,
    output logic [exPkg::ALU_W-1:0] aluOp,
    output logic                    useImm,
    output logic [exPkg::RES_W-1:0] resSel,
    output logic                    decErr
);

    always_comb begin
        // defaults cover halt, nop, branches and plain jumps
        aluOp  = exPkg::ALU_ADD;
        useImm = 1'b0;
        resSel = exPkg::RES_ALU;
        decErr = 1'b0;
        case (op)
            exPkg::OP_ADDI,
            exPkg::OP_ST,
            exPkg::OP_LD,
            exPkg::OP_STU: begin
                useImm = 1'b1;
            end
            exPkg::OP_SUBI: begin
                useImm = 1'b1;
                aluOp  = exPkg::ALU_SUB;
            end
            exPkg::OP_XORI: begin
                useImm = 1'b1;
                aluOp  = exPkg::ALU_XOR;
            end
            exPkg::OP_ANDNI: begin
                useImm = 1'b1;
                aluOp  = exPkg::ALU_ANDN;
            end
            exPkg::OP_ROLI: begin
                useImm = 1'b1;
                aluOp  = exPkg::ALU_ROL;
            end
            exPkg::OP_SLLI: begin
                useImm = 1'b1;
                aluOp  = exPkg::ALU_SLL;
            end
            exPkg::OP_RORI: begin
                useImm = 1'b1;
                aluOp  = exPkg::ALU_ROR;
            end
            exPkg::OP_SRLI: begin
                useImm = 1'b1;
                aluOp  = exPkg::ALU_SRL;
            end
            exPkg::OP_ARITH: begin
                case (fn)
                    exPkg::FN_ADD:  aluOp = exPkg::ALU_ADD;
                    exPkg::FN_SUB:  aluOp = exPkg::ALU_SUB;
                    exPkg::FN_XOR:  aluOp = exPkg::ALU_XOR;
                    exPkg::FN_ANDN: aluOp = exPkg::ALU_ANDN;
                endcase
            end
            exPkg::OP_SHIFT: begin
                case (fn)
                    exPkg::FN_ROL: aluOp = exPkg::ALU_ROL;
                    exPkg::FN_SLL: aluOp = exPkg::ALU_SLL;
                    exPkg::FN_ROR: aluOp = exPkg::ALU_ROR;
                    exPkg::FN_SRL: aluOp = exPkg::ALU_SRL;
                endcase
            end
            // compares read flags of b - a
            exPkg::OP_SEQ: begin
                aluOp  = exPkg::ALU_SUB;
                resSel = exPkg::RES_SEQ;
            end
            exPkg::OP_SLT: begin
                aluOp  = exPkg::ALU_SUB;
                resSel = exPkg::RES_SLT;
            end
            exPkg::OP_SLE: begin
                aluOp  = exPkg::ALU_SUB;
                resSel = exPkg::RES_SLE;
            end
            exPkg::OP_SCO:  resSel = exPkg::RES_SCO;
            exPkg::OP_BTR:  resSel = exPkg::RES_BTR;
            exPkg::OP_LBI:  resSel = exPkg::RES_IMM;
            exPkg::OP_SLBI: resSel = exPkg::RES_SLBI;
            exPkg::OP_JAL,
            exPkg::OP_JALR: resSel = exPkg::RES_LINK;
            exPkg::OP_BEQZ, exPkg::OP_BNEZ, exPkg::OP_BLTZ, exPkg::OP_BGEZ,
            exPkg::OP_J, exPkg::OP_JR, exPkg::OP_HALT, exPkg::OP_NOP: begin
                resSel = exPkg::RES_ALU;
            end
            default: decErr = 1'b1;
        endcase
    end

endmodule

/* exMemReg.sv */
`timescale 1ns/1ps

module exMemReg (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [exPkg::WORD_W-1:0] result,
    input  logic [exPkg::WORD_W-1:0] target,
    input  logic                     takeBranch,
    input  logic [exPkg::WORD_W-1:0] rd2Idex,
    input  logic [exPkg::REG_W-1:0]  wrRegIdex,
    input  logic                     regWriteIdex,
    input  logic                     memWriteIdex,
    input  logic                     memReadIdex,
    input  logic                     memToRegIdex,
    input  logic                     dumpIdex,
    input  logic                     haltIdex,
    output logic [exPkg::WORD_W-1:0] aluOutExmem,
    output logic [exPkg::WORD_W-1:0] pcNextExmem,
    output logic [exPkg::WORD_W-1:0] rd2Exmem,
    output logic [exPkg::REG_W-1:0]  wrRegExmem,
    output logic                     regWriteExmem,
    output logic                     memWriteExmem,
    output logic                     memReadExmem,
    output logic                     memToRegExmem,
    output logic                     dumpExmem,
    output logic                     haltExmem,
    output logic                     takeBranchExmem
);

    logic flush;

    // the instruction behind a taken branch is on the wrong path
    assign flush = takeBranchExmem;

    always_ff @(posedge clk) begin
        if (rst) begin
            aluOutExmem     <= '0;
            pcNextExmem     <= '0;
            rd2Exmem        <= '0;
            wrRegExmem      <= '0;
            regWriteExmem   <= 1'b0;
            memWriteExmem   <= 1'b0;
            memReadExmem    <= 1'b0;
            memToRegExmem   <= 1'b0;
            dumpExmem       <= 1'b0;
            haltExmem       <= 1'b0;
            takeBranchExmem <= 1'b0;
        end else begin
            aluOutExmem     <= result;
            pcNextExmem     <= target;
            rd2Exmem        <= rd2Idex;
            wrRegExmem      <= wrRegIdex;
            memToRegExmem   <= memToRegIdex;
            dumpExmem       <= dumpIdex;
            regWriteExmem   <= regWriteIdex & ~flush;
            memWriteExmem   <= memWriteIdex & ~flush;
            memReadExmem    <= memReadIdex & ~flush;
            haltExmem       <= haltIdex & ~flush;
            takeBranchExmem <= takeBranch & ~flush;
        end
    end

endmodule

/* exPkg.sv */
package exPkg;

    localparam int WORD_W = 16;
    localparam int OP_W   = 5;
    localparam int FN_W   = 2;
    localparam int REG_W  = 3;
    localparam int ALU_W  = 4;
    localparam int RES_W  = 4;
    localparam int SH_W   = 4;
    localparam int BYTE_W = 8;

    // immediate-form data ops
    localparam logic [OP_W-1:0] OP_ADDI  = 5'b01000;
    localparam logic [OP_W-1:0] OP_SUBI  = 5'b01001;
    localparam logic [OP_W-1:0] OP_XORI  = 5'b01010;
    localparam logic [OP_W-1:0] OP_ANDNI = 5'b01011;
    localparam logic [OP_W-1:0] OP_ROLI  = 5'b10100;
    localparam logic [OP_W-1:0] OP_SLLI  = 5'b10101;
    localparam logic [OP_W-1:0] OP_RORI  = 5'b10110;
    localparam logic [OP_W-1:0] OP_SRLI  = 5'b10111;
    localparam logic [OP_W-1:0] OP_ST    = 5'b10000;
    localparam logic [OP_W-1:0] OP_LD    = 5'b10001;
    localparam logic [OP_W-1:0] OP_STU   = 5'b10011;

    // register-form data ops
    localparam logic [OP_W-1:0] OP_BTR   = 5'b11001;
    localparam logic [OP_W-1:0] OP_ARITH = 5'b11011;
    localparam logic [OP_W-1:0] OP_SHIFT = 5'b11010;
    localparam logic [OP_W-1:0] OP_SEQ   = 5'b11100;
    localparam logic [OP_W-1:0] OP_SLT   = 5'b11101;
    localparam logic [OP_W-1:0] OP_SLE   = 5'b11110;
    localparam logic [OP_W-1:0] OP_SCO   = 5'b11111;
    localparam logic [OP_W-1:0] OP_LBI   = 5'b11000;
    localparam logic [OP_W-1:0] OP_SLBI  = 5'b10010;

    // branches and jumps
    localparam logic [OP_W-1:0] OP_BEQZ  = 5'b01100;
    localparam logic [OP_W-1:0] OP_BNEZ  = 5'b01101;
    localparam logic [OP_W-1:0] OP_BLTZ  = 5'b01110;
    localparam logic [OP_W-1:0] OP_BGEZ  = 5'b01111;
    localparam logic [OP_W-1:0] OP_J     = 5'b00100;
    localparam logic [OP_W-1:0] OP_JR    = 5'b00101;
    localparam logic [OP_W-1:0] OP_JAL   = 5'b00110;
    localparam logic [OP_W-1:0] OP_JALR  = 5'b00111;

    localparam logic [OP_W-1:0] OP_HALT  = 5'b00000;
    localparam logic [OP_W-1:0] OP_NOP   = 5'b00001;

    // function field, arith and shift groups
    localparam logic [FN_W-1:0] FN_ADD  = 2'b00;
    localparam logic [FN_W-1:0] FN_SUB  = 2'b01;
    localparam logic [FN_W-1:0] FN_XOR  = 2'b10;
    localparam logic [FN_W-1:0] FN_ANDN = 2'b11;
    localparam logic [FN_W-1:0] FN_ROL  = 2'b00;
    localparam logic [FN_W-1:0] FN_SLL  = 2'b01;
    localparam logic [FN_W-1:0] FN_ROR  = 2'b10;
    localparam logic [FN_W-1:0] FN_SRL  = 2'b11;

    localparam logic [ALU_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_W-1:0] ALU_XOR  = 4'd2;
    localparam logic [ALU_W-1:0] ALU_ANDN = 4'd3;
    localparam logic [ALU_W-1:0] ALU_ROL  = 4'd4;
    localparam logic [ALU_W-1:0] ALU_SLL  = 4'd5;
    localparam logic [ALU_W-1:0] ALU_ROR  = 4'd6;
    localparam logic [ALU_W-1:0] ALU_SRL  = 4'd7;

    localparam logic [RES_W-1:0] RES_ALU  = 4'd0;
    localparam logic [RES_W-1:0] RES_IMM  = 4'd1;
    localparam logic [RES_W-1:0] RES_SLBI = 4'd2;
    localparam logic [RES_W-1:0] RES_SLT  = 4'd3;
    localparam logic [RES_W-1:0] RES_SLE  = 4'd4;
    localparam logic [RES_W-1:0] RES_SEQ  = 4'd5;
    localparam logic [RES_W-1:0] RES_SCO  = 4'd6;
    localparam logic [RES_W-1:0] RES_BTR  = 4'd7;
    localparam logic [RES_W-1:0] RES_LINK = 4'd8;

endpackage

/* exResult.sv */
`timescale 1ns/1ps

module exResult (
    input  logic [exPkg::RES_W-1:0]  resSel,
    input  logic [exPkg::WORD_W-1:0] aluOut,
    input  logic                     carry,
    input  logic                     zero,
    input  logic                     neg,
    input  logic [exPkg::WORD_W-1:0] rd1,
    input  logic [exPkg::WORD_W-1:0] rd2,
    input  logic [exPkg::WORD_W-1:0] imm,
    input  logic [exPkg::WORD_W-1:0] pc2,
    output logic [exPkg::WORD_W-1:0] result
);

    logic                     sameSign;
    logic                     sltBit;
    logic                     sleBit;
    logic [exPkg::WORD_W-1:0] btrVal;
    logic [exPkg::WORD_W-1:0] slbiVal;

    assign sameSign = (rd1[exPkg::WORD_W-1] == rd2[exPkg::WORD_W-1]);

    // equal signs cannot overflow b - a, so its sign decides
    // otherwise a negative rd1 means rd1 < rd2
    assign sltBit = sameSign ? (~neg & ~zero) : rd1[exPkg::WORD_W-1];
    assign sleBit = sameSign ? ~neg : rd1[exPkg::WORD_W-1];

    always_comb begin
        for (int i = 0; i < exPkg::WORD_W; i++) begin
            btrVal[i] = rd1[exPkg::WORD_W-1-i];
        end
    end

    assign slbiVal = (rd1 << exPkg::BYTE_W) | imm;

    always_comb begin
        result = '0;
        case (resSel)
            exPkg::RES_ALU: begin
                result = aluOut;
            end
            exPkg::RES_IMM: begin
                result = imm;
            end
            exPkg::RES_SLBI: begin
                result = slbiVal;
            end
            exPkg::RES_SLT: begin
                result[0] = sltBit;
            end
            exPkg::RES_SLE: begin
                result[0] = sleBit;
            end
            exPkg::RES_SEQ: begin
                result[0] = zero;
            end
            exPkg::RES_SCO: begin
                result[0] = carry;
            end
            exPkg::RES_BTR: begin
                result = btrVal;
            end
            exPkg::RES_LINK: begin
                result = pc2;
            end
            default: begin
                result = aluOut;
            end
        endcase
    end

endmodule

/* execute.sv */
`timescale 1ns/1ps

module execute (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [exPkg::WORD_W-1:0] pc2Idex,
    input  logic [exPkg::WORD_W-1:0] rd1Idex,
    input  logic [exPkg::WORD_W-1:0] rd2Idex,
    input  logic [exPkg::WORD_W-1:0] immIdex,
    input  logic [exPkg::OP_W-1:0]   opIdex,
    input  logic [exPkg::FN_W-1:0]   fnIdex,
    input  logic [exPkg::REG_W-1:0]  wrRegIdex,
    input  logic                     regWriteIdex,
    input  logic                     memWriteIdex,
    input  logic                     memReadIdex,
    input  logic                     memToRegIdex,
    input  logic                     dumpIdex,
    input  logic                     haltIdex,
    output logic [exPkg::WORD_W-1:0] aluOutExmem,
    output logic [exPkg::WORD_W-1:0] pcNextExmem,
    output logic [exPkg::WORD_W-1:0] rd2Exmem,
    output logic [exPkg::REG_W-1:0]  wrRegExmem,
    output logic                     regWriteExmem,
    output logic                     memWriteExmem,
    output logic                     memReadExmem,
    output logic                     memToRegExmem,
    output logic                     dumpExmem,
    output logic                     haltExmem,
    output logic                     takeBranchExmem,
    output logic                     err
);

    logic [exPkg::ALU_W-1:0]  aluOp;
    logic                     useImm;
    logic [exPkg::RES_W-1:0]  resSel;
    logic                     decErr;
    logic [exPkg::WORD_W-1:0] bOperand;
    logic [exPkg::WORD_W-1:0] aluOut;
    logic                     carry;
    logic                     zero;
    logic                     neg;
    logic                     aluErr;
    logic                     takeBranch;
    logic [exPkg::WORD_W-1:0] target;
    logic [exPkg::WORD_W-1:0] result;

    exDecode u_exDecode (.op(opIdex), .fn(fnIdex), .aluOp(aluOp), .useImm(useImm),
                         .resSel(resSel), .decErr(decErr));

    assign bOperand = useImm ? immIdex : rd2Idex;

    exAlu u_exAlu (.a(rd1Idex), .b(bOperand), .aluOp(aluOp), .y(aluOut), .carry(carry),
                   .zero(zero), .neg(neg), .aluErr(aluErr));

    branchUnit u_branchUnit (.op(opIdex), .pc2(pc2Idex), .rd1(rd1Idex), .imm(immIdex),
                             .takeBranch(takeBranch), .target(target));

    exResult u_exResult (.resSel(resSel), .aluOut(aluOut), .carry(carry), .zero(zero),
                         .neg(neg), .rd1(rd1Idex), .rd2(rd2Idex), .imm(immIdex),
                         .pc2(pc2Idex), .result(result));

    // undefined opcode, or an ALU op outside the decoded set
    assign err = decErr | aluErr;

    exMemReg u_exMemReg (
        .clk(clk), .rst(rst), .result(result), .target(target), .takeBranch(takeBranch),
        .rd2Idex(rd2Idex), .wrRegIdex(wrRegIdex), .regWriteIdex(regWriteIdex),
        .memWriteIdex(memWriteIdex), .memReadIdex(memReadIdex),
        .memToRegIdex(memToRegIdex), .dumpIdex(dumpIdex), .haltIdex(haltIdex),
        .aluOutExmem(aluOutExmem), .pcNextExmem(pcNextExmem), .rd2Exmem(rd2Exmem),
        .wrRegExmem(wrRegExmem), .regWriteExmem(regWriteExmem),
        .memWriteExmem(memWriteExmem), .memReadExmem(memReadExmem),
        .memToRegExmem(memToRegExmem), .dumpExmem(dumpExmem), .haltExmem(haltExmem),
        .takeBranchExmem(takeBranchExmem)
    );

endmodule

/* execute_assert.sv */
`timescale 1ns/1ps

module executeAssert (
    input logic                     clk,
    input logic                     rst,
    input logic [exPkg::WORD_W-1:0] aluOutExmem,
    input logic [exPkg::WORD_W-1:0] pcNextExmem,
    input logic [exPkg::WORD_W-1:0] rd2Exmem,
    input logic [exPkg::REG_W-1:0]  wrRegExmem,
    input logic                     regWriteExmem,
    input logic                     memWriteExmem,
    input logic                     memReadExmem,
    input logic                     memToRegExmem,
    input logic                     dumpExmem,
    input logic                     haltExmem,
    input logic                     takeBranchExmem
);

    int failCount = 0;

    // register comes out of reset cleared
    resetClears: assert property (@(posedge clk) rst |=>
        (aluOutExmem == '0 && pcNextExmem == '0 && rd2Exmem == '0 && wrRegExmem == '0
         && !regWriteExmem && !memWriteExmem && !memReadExmem && !memToRegExmem
         && !dumpExmem && !haltExmem && !takeBranchExmem))
        else begin
            failCount = failCount + 1;
            $error("EX/MEM outputs not zero after reset");
        end

    // instruction in the branch shadow is squashed
    flushSquashes: assert property (@(posedge clk) disable iff (rst) takeBranchExmem |=>
        (!regWriteExmem && !memWriteExmem && !memReadExmem && !haltExmem && !takeBranchExmem))
        else begin
            failCount = failCount + 1;
            $error("controls behind a taken branch were not squashed");
        end

    noReadAndWrite: assert property (@(posedge clk) disable iff (rst)
        !(memReadExmem && memWriteExmem))
        else begin
            failCount = failCount + 1;
            $error("memory read and write both active");
        end

endmodule

/* flist.f */
exPkg.sv
exDecode.sv
exAlu.sv
branchUnit.sv
exResult.sv
exMemReg.sv
execute.sv
execute_assert.sv
tbExecute.sv

/* tbExecute.sv */
`timescale 1ns/1ps

module tbExecute;

    logic                     clk = 1'b0;
    logic                     rst;
    logic [exPkg::WORD_W-1:0] pc2Idex, rd1Idex, rd2Idex, immIdex;
    logic [exPkg::OP_W-1:0]   opIdex;
    logic [exPkg::FN_W-1:0]   fnIdex;
    logic [exPkg::REG_W-1:0]  wrRegIdex;
    // regWrite, memWrite, memRead, memToReg, dump, halt
    logic [5:0]               ctrlIdex;
    logic [exPkg::WORD_W-1:0] aluOutExmem, pcNextExmem, rd2Exmem;
    logic [exPkg::REG_W-1:0]  wrRegExmem;
    logic                     regWriteExmem, memWriteExmem, memReadExmem, memToRegExmem;
    logic                     dumpExmem, haltExmem, takeBranchExmem, err;

    // expected EX/MEM contents for the instruction in flight
    string                    pName = "reset";
    logic                     pCheckRes = 1'b1;
    logic                     pTake = 1'b0;
    logic [exPkg::WORD_W-1:0] pRes = '0, pTarget = '0, pRd2 = '0;
    logic [exPkg::REG_W-1:0]  pWrReg = '0;
    logic [5:0]               pCtrl = '0;
    int                       cycles = 0;

    execute u_execute (.*, .regWriteIdex(ctrlIdex[5]), .memWriteIdex(ctrlIdex[4]),
                       .memReadIdex(ctrlIdex[3]), .memToRegIdex(ctrlIdex[2]),
                       .dumpIdex(ctrlIdex[1]), .haltIdex(ctrlIdex[0]));

    bind exMemReg executeAssert u_executeAssert (.*);

    always #10 clk = ~clk;

    // roughly 1100 cycles of tests, so 2000 leaves margin
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == 2000) begin
            abortRun("timeout: the tests did not finish within 2000 cycles");
        end
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic checkWord(input string name, input logic [exPkg::WORD_W-1:0] exp, act);
        if (act !== exp) begin
            abortRun($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic checkBit(input string name, input logic exp, act);
        if (act !== exp) begin
            abortRun($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic checkReg(input string name, input logic [exPkg::REG_W-1:0] exp, act);
        if (act !== exp) begin
            abortRun($sformatf("** Error %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    function automatic logic [exPkg::WORD_W-1:0] randWord();
        return 16'($urandom);
    endfunction

    // kinds 0..7 are add, sub, xor, andn, rol, sll, ror, srl
    function automatic logic [exPkg::WORD_W-1:0] aluModel(input int kind,
                                                          input logic [exPkg::WORD_W-1:0] a, b);
        logic [exPkg::WORD_W-1:0] r;
        int                       s;
        r = '0;
        s = b[3:0];
        case (kind)
            0: r = a + b;
            1: r = b - a;
            2: r = a ^ b;
            3: r = a & ~b;
            4: for (int i = 0; i < exPkg::WORD_W; i++) r[(i + s) % exPkg::WORD_W] = a[i];
            5: r = a << s;
            6: for (int i = 0; i < exPkg::WORD_W; i++) r[i] = a[(i + s) % exPkg::WORD_W];
            7: r = a >> s;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic [exPkg::WORD_W-1:0] expResult(
        input logic [exPkg::OP_W-1:0] op, input logic [exPkg::FN_W-1:0] fn,
        input logic [exPkg::WORD_W-1:0] a, b, imm, pc, output logic known, output logic defined);
        logic [exPkg::WORD_W:0]   wide;
        logic [exPkg::WORD_W-1:0] rev;
        wide = {1'b0, a} + {1'b0, b};
        rev = {<<{a}};
        known = 1'b1;
        defined = 1'b1;
        case (op)
            exPkg::OP_ADDI, exPkg::OP_ST, exPkg::OP_LD, exPkg::OP_STU: return a + imm;
            exPkg::OP_SUBI:  return aluModel(1, a, imm);
            exPkg::OP_XORI:  return aluModel(2, a, imm);
            exPkg::OP_ANDNI: return aluModel(3, a, imm);
            exPkg::OP_ROLI:  return aluModel(4, a, imm);
            exPkg::OP_SLLI:  return aluModel(5, a, imm);
            exPkg::OP_RORI:  return aluModel(6, a, imm);
            exPkg::OP_SRLI:  return aluModel(7, a, imm);
            // function order is add/sub/xor/andn and rol/sll/ror/srl
            exPkg::OP_ARITH: return aluModel(int'(fn), a, b);
            exPkg::OP_SHIFT: return aluModel(4 + int'(fn), a, b);
            exPkg::OP_SEQ:   return {15'd0, a == b};
            exPkg::OP_SLT:   return {15'd0, $signed(a) < $signed(b)};
            exPkg::OP_SLE:   return {15'd0, $signed(a) <= $signed(b)};
            exPkg::OP_SCO:   return {15'd0, wide[exPkg::WORD_W]};
            exPkg::OP_BTR:   return rev;
            exPkg::OP_LBI:   return imm;
            exPkg::OP_SLBI:  return (a << 8) | imm;
            exPkg::OP_JAL, exPkg::OP_JALR: return pc;
            exPkg::OP_BEQZ, exPkg::OP_BNEZ, exPkg::OP_BLTZ, exPkg::OP_BGEZ,
            exPkg::OP_J, exPkg::OP_JR, exPkg::OP_HALT, exPkg::OP_NOP: known = 1'b0;
            default: begin
                known = 1'b0;
                defined = 1'b0;
            end
        endcase
        return '0;
    endfunction

    function automatic logic expTake(input logic [exPkg::OP_W-1:0] op,
                                     input logic [exPkg::WORD_W-1:0] a);
        case (op)
            exPkg::OP_BEQZ: return a == '0;
            exPkg::OP_BNEZ: return a != '0;
            exPkg::OP_BLTZ: return a[exPkg::WORD_W-1];
            exPkg::OP_BGEZ: return !a[exPkg::WORD_W-1];
            exPkg::OP_J, exPkg::OP_JR, exPkg::OP_JAL, exPkg::OP_JALR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic checkPending();
        checkBit({pName, " regWrite"}, pCtrl[5], regWriteExmem);
        checkBit({pName, " memWrite"}, pCtrl[4], memWriteExmem);
        checkBit({pName, " memRead"}, pCtrl[3], memReadExmem);
        checkBit({pName, " memToReg"}, pCtrl[2], memToRegExmem);
        checkBit({pName, " dump"}, pCtrl[1], dumpExmem);
        checkBit({pName, " halt"}, pCtrl[0], haltExmem);
        checkBit({pName, " takeBranch"}, pTake, takeBranchExmem);
        checkWord({pName, " pcNext"}, pTarget, pcNextExmem);
        checkWord({pName, " rd2"}, pRd2, rd2Exmem);
        checkReg({pName, " wrReg"}, pWrReg, wrRegExmem);
        if (pCheckRes) begin
            checkWord({pName, " aluOut"}, pRes, aluOutExmem);
        end
    endtask

    // drive one instruction, then check the one captured at this edge
    task automatic issue(input string name, input logic [exPkg::OP_W-1:0] op,
                         input logic [exPkg::FN_W-1:0] fn, input logic [exPkg::WORD_W-1:0] a,
                         b, imm, pc, input logic [exPkg::REG_W-1:0] wr, input logic [5:0] ctrl);
        logic                     known;
        logic                     defined;
        logic                     take;
        logic [exPkg::WORD_W-1:0] res;
        @(posedge clk);
        opIdex <= op;
        fnIdex <= fn;
        rd1Idex <= a;
        rd2Idex <= b;
        immIdex <= imm;
        pc2Idex <= pc;
        wrRegIdex <= wr;
        ctrlIdex <= ctrl;
        @(negedge clk);
        res = expResult(op, fn, a, b, imm, pc, known, defined);
        checkBit({name, " err"}, !defined, err);
        checkPending();
        take = expTake(op, a);
        pTarget = take ? (((op == exPkg::OP_JR) || (op == exPkg::OP_JALR)) ? a : pc) + imm : pc;
        // behind a taken branch only memToReg and dump survive
        pCtrl = pTake ? (ctrl & 6'b000110) : ctrl;
        pTake = take & !pTake;
        pName = name;
        pRes = res;
        pCheckRes = known;
        pRd2 = b;
        pWrReg = wr;
    endtask

    task automatic testErr();
        for (int op = 0; op < 32; op++) begin
            issue($sformatf("err op %0d", op), op[4:0], 2'b00, '0, '0, '0, '0, 3'd0, 6'd0);
        end
    endtask

    task automatic testAlu();
        logic [exPkg::OP_W-1:0] immOps [8];
        immOps = '{exPkg::OP_ADDI, exPkg::OP_SUBI, exPkg::OP_XORI, exPkg::OP_ANDNI,
                   exPkg::OP_ROLI, exPkg::OP_SLLI, exPkg::OP_RORI, exPkg::OP_SRLI};
        for (int k = 0; k < 8; k++) begin
            for (int n = 0; n < 50; n++) begin
                issue($sformatf("alu reg %0d", k), (k < 4) ? exPkg::OP_ARITH : exPkg::OP_SHIFT,
                      k[1:0], randWord(), randWord(), randWord(), randWord(), 3'($urandom),
                      6'b100000);
                issue($sformatf("alu imm %0d", k), immOps[k], 2'b00, randWord(), randWord(),
                      randWord(), randWord(), 3'($urandom), 6'b100000);
            end
        end
    endtask

    task automatic testCompare();
        logic [exPkg::WORD_W-1:0] edgeA [8];
        logic [exPkg::WORD_W-1:0] edgeB [8];
        logic [exPkg::OP_W-1:0]   setOps [4];
        edgeA = '{16'h0000, 16'h7fff, 16'h8000, 16'h8000, 16'hffff, 16'h0001, 16'h1234, 16'hffff};
        edgeB = '{16'h0000, 16'h8000, 16'h7fff, 16'h8000, 16'h0001, 16'hffff, 16'h1234, 16'hffff};
        setOps = '{exPkg::OP_SEQ, exPkg::OP_SLT, exPkg::OP_SLE, exPkg::OP_SCO};
        for (int k = 0; k < 4; k++) begin
            for (int n = 0; n < 18; n++) begin
                issue($sformatf("set op %0d", k), setOps[k], 2'b00,
                      (n < 8) ? edgeA[n] : randWord(), (n < 8) ? edgeB[n] : randWord(),
                      randWord(), randWord(), 3'($urandom), 6'b100000);
            end
        end
    endtask

    task automatic testMisc();
        logic [exPkg::OP_W-1:0] ops [6];
        logic [5:0]             ctrls [6];
        ops = '{exPkg::OP_BTR, exPkg::OP_LBI, exPkg::OP_SLBI, exPkg::OP_ST, exPkg::OP_LD,
                exPkg::OP_STU};
        ctrls = '{6'b100000, 6'b100000, 6'b100000, 6'b010000, 6'b101100, 6'b110000};
        for (int k = 0; k < 6; k++) begin
            for (int n = 0; n < 10; n++) begin
                issue($sformatf("misc op %0d", k), ops[k], 2'b00, randWord(), randWord(),
                      randWord(), randWord(), 3'($urandom), ctrls[k]);
            end
        end
    endtask

    task automatic testBranch();
        logic [exPkg::WORD_W-1:0] vals [4];
        logic [exPkg::OP_W-1:0]   ops [8];
        vals = '{16'h0000, 16'h0001, 16'h8000, 16'h7fff};
        ops = '{exPkg::OP_BEQZ, exPkg::OP_BNEZ, exPkg::OP_BLTZ, exPkg::OP_BGEZ,
                exPkg::OP_J, exPkg::OP_JR, exPkg::OP_JAL, exPkg::OP_JALR};
        for (int k = 0; k < 8; k++) begin
            for (int n = 0; n < 4; n++) begin
                issue($sformatf("branch op %0d", k), ops[k], 2'b00,
                      (k < 4) ? vals[n] : randWord(), randWord(), randWord(), randWord(),
                      3'($urandom), (k >= 6) ? 6'b100000 : 6'b000000);
                // a nop keeps the next branch out of the flush shadow
                issue("branch gap", exPkg::OP_NOP, 2'b00, '0, '0, '0, '0, 3'd0, 6'd0);
            end
        end
    endtask

    task automatic testFlush();
        issue("flush beqz", exPkg::OP_BEQZ, 2'b00, 16'h0000, 16'h1111, 16'h0040, 16'h0200,
              3'd1, 6'b000000);
        issue("flush shadow", exPkg::OP_ST, 2'b00, 16'h0100, 16'h2222, 16'h0004, 16'h0202,
              3'd2, 6'b110111);
        issue("flush after", exPkg::OP_LD, 2'b00, 16'h0100, 16'h3333, 16'h0008, 16'h0204,
              3'd3, 6'b101111);
        issue("flush bnez", exPkg::OP_BNEZ, 2'b00, 16'h0005, 16'h4444, 16'h0010, 16'h0206,
              3'd4, 6'b000000);
        issue("flush jump", exPkg::OP_J, 2'b00, 16'h0000, 16'h5555, 16'h0020, 16'h0208,
              3'd5, 6'b001001);
        issue("flush resume", exPkg::OP_ADDI, 2'b00, 16'h0007, 16'h6666, 16'h0003, 16'h020a,
              3'd6, 6'b100000);
    endtask

    task automatic testPassThrough();
        for (int n = 0; n < 20; n++) begin
            issue("pass fields", exPkg::OP_ADDI, 2'b00, randWord(), randWord(), randWord(),
                  randWord(), 3'($urandom), {1'b1, 2'b00, 2'($urandom), 1'b0});
        end
    endtask

    initial begin
        void'($urandom(32'h9317a234));
        rst = 1'b1;
        opIdex = exPkg::OP_NOP;
        fnIdex = '0;
        rd1Idex = '0;
        rd2Idex = '0;
        immIdex = '0;
        pc2Idex = '0;
        wrRegIdex = '0;
        ctrlIdex = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkPending();
        pName = "idle";
        pCheckRes = 1'b0;
        testErr();
        testAlu();
        testCompare();
        testMisc();
        testBranch();
        testFlush();
        testPassThrough();
        issue("drain", exPkg::OP_NOP, 2'b00, '0, '0, '0, '0, 3'd0, 6'd0);
        repeat (2) @(posedge clk);
        if (u_execute.u_exMemReg.u_executeAssert.failCount == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failures in the EX/MEM register");
        end
    end

endmodule
